// File: legv8Pkg.sv
package legv8Pkg;

	localparam int DATA_W = 64;
	localparam int ADDR_W = 64;
	localparam int REG_ADDR_W = 5;
	localparam int INSTR_W = 32;
	localparam int NUM_REGS = 32;
	localparam logic [REG_ADDR_W-1:0] ZERO_REG = 5'd31; // XZR
	localparam int WORD_BYTE_BITS = 3; // 8-byte data words

	// Instruction field positions
	localparam int OP_LSB = 21;
	localparam int OP_W = 11;
	localparam int RD_LSB = 0; // Rd and Rt share bits 4:0
	localparam int RN_LSB = 5;
	localparam int RM_LSB = 16;
	localparam int DADDR_LSB = 12;
	localparam int DADDR_W = 9;
	localparam int IMM_LSB = 10;
	localparam int IMM_W = 12;
	localparam int CB_LSB = 5;
	localparam int CB_W = 19;
	localparam int BR_LSB = 0;
	localparam int BR_W = 26;

	// Full 11-bit opcodes
	localparam logic [10:0] OPC_NOP = 11'b11010101000;
	localparam logic [10:0] OPC_LDUR = 11'b11111000010;
	localparam logic [10:0] OPC_STUR = 11'b11111000000;
	localparam logic [10:0] OPC_ADD = 11'b10001011000;
	localparam logic [10:0] OPC_SUB = 11'b11001011000;
	localparam logic [10:0] OPC_AND = 11'b10001010000;
	localparam logic [10:0] OPC_ORR = 11'b10101010000;
	localparam logic [10:0] OPC_HALT = 11'b11111111111;

	// Prefix opcodes matched on the upper bits only
	localparam logic [9:0] OPC_ADDI = 10'b1001000100;
	localparam logic [7:0] OPC_CBZ = 8'b10110100;
	localparam logic [7:0] OPC_CBNZ = 8'b10110101;
	localparam logic [5:0] OPC_B = 6'b000101;

	typedef enum logic [3:0] {
		opNop, opLdur, opStur, opAdd, opSub, opAnd, opOrr,
		opAddi, opCbz, opCbnz, opB, opHalt, opInvalid
	} opClassT;

	typedef enum logic [1:0] {
		aluMem = 2'b00,
		aluBranch = 2'b01,
		aluRtype = 2'b10
	} aluOpT;

	typedef enum logic [1:0] {
		srcReg = 2'b00,
		srcDaddr = 2'b01, // Signed 9-bit D-type offset
		srcImm = 2'b10 // Zero-extended 12-bit immediate
	} aluSrcT;

	typedef enum logic [2:0] {
		aluAddOp, aluSubOp, aluAndOp, aluOrrOp, aluPassB
	} aluCtrlT;

endpackage

// File: ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
	import legv8Pkg::*;

	logic reg2Loc;
	logic branch;
	logic branchZero;
	logic branchNonZero;
	logic memRead;
	logic memToReg;
	logic memWrite;
	logic regWrite;
	aluOpT aluOp;
	aluSrcT aluSrc;

	modport decoder (output reg2Loc, branch, branchZero, branchNonZero, memRead,
		memToReg, memWrite, regWrite, aluOp, aluSrc);

	modport datapath (input reg2Loc, branch, branchZero, branchNonZero, memRead,
		memToReg, memWrite, regWrite, aluOp, aluSrc);

endinterface

// File: cpuControl.sv
`timescale 1ns/1ps

module cpuControl (
	input logic [legv8Pkg::OP_W-1:0] instrOp,
	ctrlIf.decoder ctrl,
	output legv8Pkg::opClassT opClass,
	output logic invalidOp
);
	import legv8Pkg::*;

	// Exact opcodes first, then the 10, 8 and 6 bit prefixes
	always_comb
	begin
		case (instrOp)
			OPC_NOP: opClass = opNop;
			OPC_LDUR: opClass = opLdur;
			OPC_STUR: opClass = opStur;
			OPC_ADD: opClass = opAdd;
			OPC_SUB: opClass = opSub;
			OPC_AND: opClass = opAnd;
			OPC_ORR: opClass = opOrr;
			OPC_HALT: opClass = opHalt;
			default:
				case (instrOp[OP_W-1 -: 10])
					OPC_ADDI: opClass = opAddi;
					default:
						case (instrOp[OP_W-1 -: 8])
							OPC_CBZ: opClass = opCbz;
							OPC_CBNZ: opClass = opCbnz;
							default:
								if (instrOp[OP_W-1 -: 6] == OPC_B)
									opClass = opB;
								else
									opClass = opInvalid;
						endcase
				endcase
		endcase
	end

	always_comb
	begin
		ctrl.reg2Loc = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.branchZero = 1'b0;
		ctrl.branchNonZero = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.aluOp = aluMem;
		ctrl.aluSrc = srcReg;
		case (opClass)
			opLdur:
			begin
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = srcDaddr;
				ctrl.regWrite = 1'b1;
			end
			opStur:
			begin
				ctrl.reg2Loc = 1'b1; // Store data comes from Rt
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = srcDaddr;
			end
			opAdd, opSub, opAnd, opOrr:
			begin
				ctrl.aluOp = aluRtype;
				ctrl.regWrite = 1'b1;
			end
			opAddi:
			begin
				ctrl.aluOp = aluRtype;
				ctrl.aluSrc = srcImm;
				ctrl.regWrite = 1'b1;
			end
			opCbz, opCbnz:
			begin
				ctrl.reg2Loc = 1'b1; // Test Rt through the ALU
				ctrl.branchZero = (opClass == opCbz);
				ctrl.branchNonZero = (opClass == opCbnz);
				ctrl.aluOp = aluRtype;
			end
			opB:
			begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = aluBranch;
			end
			default: ; // NOP, HALT and unknown opcodes leave all control low
		endcase
	end

	assign invalidOp = (opClass == opInvalid);

endmodule

// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input legv8Pkg::aluOpT aluOp,
	input legv8Pkg::opClassT opClass,
	input logic [legv8Pkg::DATA_W-1:0] a,
	input logic [legv8Pkg::DATA_W-1:0] b,
	output logic [legv8Pkg::DATA_W-1:0] result,
	output logic zero
);
	import legv8Pkg::*;

	aluCtrlT aluCtrl;

	// ALU control
	always_comb
	begin
		case (aluOp)
			aluMem: aluCtrl = aluAddOp; // Base plus offset
			aluBranch: aluCtrl = aluPassB;
			aluRtype:
				case (opClass)
					opAdd, opAddi: aluCtrl = aluAddOp;
					opSub: aluCtrl = aluSubOp;
					opAnd: aluCtrl = aluAndOp;
					opOrr: aluCtrl = aluOrrOp;
					default: aluCtrl = aluPassB; // CBZ/CBNZ test Rt
				endcase
			default: aluCtrl = aluAddOp;
		endcase
	end

	always_comb
	begin
		case (aluCtrl)
			aluAddOp: result = a + b;
			aluSubOp: result = a - b;
			aluAndOp: result = a & b;
			aluOrrOp: result = a | b;
			aluPassB: result = b;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic [legv8Pkg::REG_ADDR_W-1:0] readReg1,
	input logic [legv8Pkg::REG_ADDR_W-1:0] readReg2,
	output logic [legv8Pkg::DATA_W-1:0] readData1,
	output logic [legv8Pkg::DATA_W-1:0] readData2,
	input logic writeEn,
	input logic [legv8Pkg::REG_ADDR_W-1:0] writeReg,
	input logic [legv8Pkg::DATA_W-1:0] writeData
);
	import legv8Pkg::*;

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (writeEn && writeReg != ZERO_REG)
		begin
			regs[writeReg] <= writeData;
		end
	end

	// XZR always reads zero
	assign readData1 = (readReg1 == ZERO_REG) ? '0 : regs[readReg1];
	assign readData2 = (readReg2 == ZERO_REG) ? '0 : regs[readReg2];

endmodule

// File: dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
	parameter int DMEM_WORDS = 32
) (
	input logic clk,
	input logic rstN,
	input logic [legv8Pkg::DATA_W-1:0] addr,
	input logic writeEn,
	input logic [legv8Pkg::DATA_W-1:0] writeData,
	output logic [legv8Pkg::DATA_W-1:0] readData
);
	import legv8Pkg::*;

	localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

	logic [DATA_W-1:0] mem [DMEM_WORDS];
	logic [DATA_W-1:0] wordNum;
	logic [IDX_W-1:0] wordIdx;

	assign wordNum = addr >> WORD_BYTE_BITS;
	assign wordIdx = IDX_W'(wordNum % DATA_W'(DMEM_WORDS)); // Wraps around the array

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (writeEn)
			mem[wordIdx] <= writeData;
	end

	assign readData = mem[wordIdx];

endmodule

// File: legv8Core.sv
`timescale 1ns/1ps

module legv8Core #(
	parameter int DMEM_WORDS = 32,
	parameter logic [legv8Pkg::ADDR_W-1:0] RESET_PC = '0
) (
	input logic clk,
	input logic rstN,
	input logic [legv8Pkg::INSTR_W-1:0] instr,
	output logic [legv8Pkg::ADDR_W-1:0] instrAddr,
	output logic wbValid,
	output logic [legv8Pkg::REG_ADDR_W-1:0] wbReg,
	output logic [legv8Pkg::DATA_W-1:0] wbData,
	output logic storeValid,
	output logic [legv8Pkg::DATA_W-1:0] storeAddr,
	output logic [legv8Pkg::DATA_W-1:0] storeData,
	output logic halted,
	output logic invalidOp
);
	import legv8Pkg::*;

	ctrlIf ctrl ();

	opClassT opClass;
	logic decInvalid;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] pcNext;
	logic [ADDR_W-1:0] branchOff;
	logic [ADDR_W-1:0] cbOffExt;
	logic [ADDR_W-1:0] brOffExt;
	logic [REG_ADDR_W-1:0] rn;
	logic [REG_ADDR_W-1:0] rd;
	logic [REG_ADDR_W-1:0] rm;
	logic [REG_ADDR_W-1:0] readReg2;
	logic [DATA_W-1:0] readData1;
	logic [DATA_W-1:0] readData2;
	logic [DATA_W-1:0] dAddrExt;
	logic [DATA_W-1:0] aluImmExt;
	logic [DATA_W-1:0] aluB;
	logic [DATA_W-1:0] aluResult;
	logic [DATA_W-1:0] memReadData;
	logic [DATA_W-1:0] loadData;
	logic aluZero;
	logic branchTaken;
	logic isHalt;

	cpuControl i_cpuControl (
		.instrOp(instr[OP_LSB +: OP_W]),
		.ctrl(ctrl.decoder),
		.opClass(opClass),
		.invalidOp(decInvalid)
	);

	// Rt shares the Rd slot
	assign rn = instr[RN_LSB +: REG_ADDR_W];
	assign rd = instr[RD_LSB +: REG_ADDR_W];
	assign rm = instr[RM_LSB +: REG_ADDR_W];
	assign readReg2 = ctrl.reg2Loc ? rd : rm;

	// Immediates
	assign dAddrExt = {{(DATA_W-DADDR_W){instr[DADDR_LSB+DADDR_W-1]}},
		instr[DADDR_LSB +: DADDR_W]};
	assign aluImmExt = {{(DATA_W-IMM_W){1'b0}}, instr[IMM_LSB +: IMM_W]};
	assign cbOffExt = {{(ADDR_W-CB_W){instr[CB_LSB+CB_W-1]}}, instr[CB_LSB +: CB_W]};
	assign brOffExt = {{(ADDR_W-BR_W){instr[BR_LSB+BR_W-1]}}, instr[BR_LSB +: BR_W]};

	regFile i_regFile (
		.clk(clk),
		.rstN(rstN),
		.readReg1(rn),
		.readReg2(readReg2),
		.readData1(readData1),
		.readData2(readData2),
		.writeEn(wbValid),
		.writeReg(rd),
		.writeData(wbData)
	);

	always_comb
	begin
		case (ctrl.aluSrc)
			srcDaddr: aluB = dAddrExt;
			srcImm: aluB = aluImmExt;
			default: aluB = readData2;
		endcase
	end

	aluUnit i_aluUnit (
		.aluOp(ctrl.aluOp),
		.opClass(opClass),
		.a(readData1),
		.b(aluB),
		.result(aluResult),
		.zero(aluZero)
	);

	dataMemory #(
		.DMEM_WORDS(DMEM_WORDS)
	) i_dataMemory (
		.clk(clk),
		.rstN(rstN),
		.addr(aluResult),
		.writeEn(storeValid),
		.writeData(readData2),
		.readData(memReadData)
	);

	assign loadData = ctrl.memRead ? memReadData : '0;

	// Nothing retires once halted
	assign wbValid = ctrl.regWrite && !halted && rd != ZERO_REG;
	assign wbReg = rd;
	assign wbData = ctrl.memToReg ? loadData : aluResult;
	assign storeValid = ctrl.memWrite && !halted;
	assign storeAddr = aluResult;
	assign storeData = readData2;
	assign invalidOp = decInvalid && !halted;

	// Next PC
	assign branchTaken = ctrl.branch || (ctrl.branchZero && aluZero) ||
		(ctrl.branchNonZero && !aluZero);
	assign branchOff = ctrl.branch ? brOffExt : cbOffExt;
	assign isHalt = (opClass == opHalt);

	always_comb
	begin
		if (halted || isHalt)
			pcNext = pc; // Freeze on HALT
		else if (branchTaken)
			pcNext = pc + (branchOff << 2);
		else
			pcNext = pc + ADDR_W'(4);
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc <= RESET_PC;
			halted <= 1'b0;
		end
		else
		begin
			pc <= pcNext;
			halted <= halted || isHalt;
		end
	end

	assign instrAddr = pc;

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 5
) (
	input logic resetReq,
	output logic clk,
	output logic rstN
);
	int holdCnt = RESET_CYCLES; // Power-on reset

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset only moves on the falling edge
	always @(negedge clk)
	begin
		if (resetReq)
			holdCnt <= RESET_CYCLES;
		else if (holdCnt != 0)
			holdCnt <= holdCnt - 1;
	end

	assign rstN = (holdCnt == 0);

endmodule

// File: tbChecker.sv
`timescale 1ns/1ps

module tbChecker #(
	parameter int DMEM_WORDS = 32,
	parameter logic [legv8Pkg::ADDR_W-1:0] RESET_PC = '0,
	parameter int PROG_DEPTH = 64
) (
	input logic clk,
	input logic rstN,
	input logic [legv8Pkg::ADDR_W-1:0] instrAddr,
	input logic wbValid,
	input logic [legv8Pkg::REG_ADDR_W-1:0] wbReg,
	input logic [legv8Pkg::DATA_W-1:0] wbData,
	input logic storeValid,
	input logic [legv8Pkg::DATA_W-1:0] storeAddr,
	input logic [legv8Pkg::DATA_W-1:0] storeData,
	input logic halted,
	input logic invalidOp,
	output int errCount,
	output int invalidSeen
);
	import legv8Pkg::*;

	localparam int SAMPLE_DELAY = 5; // Quarter period after the falling edge
	localparam int PROG_IDX_W = $clog2(PROG_DEPTH);
	localparam logic [ADDR_W-1:0] FETCH_LIMIT = ADDR_W'(PROG_DEPTH * 4);

	logic [DATA_W-1:0] mRegs [NUM_REGS];
	logic [DATA_W-1:0] mMem [DMEM_WORDS];
	logic [ADDR_W-1:0] mPc;
	logic mHalted;

	initial
	begin
		errCount = 0;
		invalidSeen = 0;
	end

	function automatic logic [DATA_W-1:0] readReg(input logic [REG_ADDR_W-1:0] r);
		return (r == ZERO_REG) ? '0 : mRegs[r];
	endfunction

	function automatic int memIndex(input logic [DATA_W-1:0] addr);
		return int'((addr >> WORD_BYTE_BITS) % DATA_W'(DMEM_WORDS));
	endfunction

	task automatic reportFail(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		errCount++;
	endtask

	task automatic checkWord(input string what, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp)
			reportFail($sformatf("%s expected 0x%0h, got 0x%0h", what, exp, act));
	endtask

	task automatic checkBit(input string what, input logic exp, input logic act);
		if (act !== exp)
			reportFail($sformatf("%s expected %b, got %b", what, exp, act));
	endtask

	task automatic resetModel;
		for (int i = 0; i < NUM_REGS; i++)
			mRegs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			mMem[i] = '0;
		mPc = RESET_PC;
		mHalted = 1'b0;
	endtask

	// One instruction of the ISA model against the DUT's cycle
	task automatic stepModel;
		logic [INSTR_W-1:0] w;
		logic [REG_ADDR_W-1:0] rdIdx;
		logic [DATA_W-1:0] opA;
		logic [DATA_W-1:0] rtVal;
		logic [DATA_W-1:0] res;
		logic [DATA_W-1:0] addr;
		logic [ADDR_W-1:0] nextPc;
		logic expWb;
		logic expStore;
		logic expInvalid;
		logic expHalt;
		checkWord("instrAddr", mPc, instrAddr);
		checkBit("halted", mHalted, halted);
		if (mHalted)
		begin
			checkBit("wbValid after HALT", 1'b0, wbValid);
			checkBit("storeValid after HALT", 1'b0, storeValid);
			checkBit("invalidOp after HALT", 1'b0, invalidOp);
		end
		else
		begin
			w = (mPc < FETCH_LIMIT) ? tbTop.progMem[mPc[2 +: PROG_IDX_W]] : {OPC_HALT, 21'b0};
			rdIdx = w[4:0];
			opA = readReg(w[9:5]);
			rtVal = readReg(rdIdx);
			addr = opA + {{55{w[20]}}, w[20:12]};
			res = '0;
			expWb = 1'b0;
			expStore = 1'b0;
			expInvalid = 1'b0;
			expHalt = 1'b0;
			nextPc = mPc + ADDR_W'(4);
			case (w[31:21])
				OPC_NOP: ;
				OPC_HALT:
				begin
					expHalt = 1'b1;
					nextPc = mPc;
				end
				OPC_LDUR:
				begin
					res = mMem[memIndex(addr)];
					expWb = 1'b1;
				end
				OPC_STUR: expStore = 1'b1;
				OPC_ADD: {expWb, res} = {1'b1, opA + readReg(w[20:16])};
				OPC_SUB: {expWb, res} = {1'b1, opA - readReg(w[20:16])};
				OPC_AND: {expWb, res} = {1'b1, opA & readReg(w[20:16])};
				OPC_ORR: {expWb, res} = {1'b1, opA | readReg(w[20:16])};
				default:
					if (w[31:22] == OPC_ADDI)
						{expWb, res} = {1'b1, opA + {52'b0, w[21:10]}};
					else if ((w[31:24] == OPC_CBZ && rtVal == '0) ||
						(w[31:24] == OPC_CBNZ && rtVal != '0))
						nextPc = mPc + ({{45{w[23]}}, w[23:5]} << 2);
					else if (w[31:24] == OPC_CBZ || w[31:24] == OPC_CBNZ)
						nextPc = mPc + ADDR_W'(4); // Not taken
					else if (w[31:26] == OPC_B)
						nextPc = mPc + ({{38{w[25]}}, w[25:0]} << 2);
					else
						expInvalid = 1'b1;
			endcase
			if (rdIdx == ZERO_REG)
				expWb = 1'b0; // XZR is never written
			checkBit("wbValid", expWb, wbValid);
			if (expWb && wbValid)
			begin
				checkWord("wbReg", DATA_W'(rdIdx), DATA_W'(wbReg));
				checkWord("wbData", res, wbData);
			end
			checkBit("storeValid", expStore, storeValid);
			if (expStore && storeValid)
			begin
				checkWord("storeAddr", addr, storeAddr);
				checkWord("storeData", rtVal, storeData);
			end
			checkBit("invalidOp", expInvalid, invalidOp);
			if (expInvalid && invalidOp)
				invalidSeen++;
			if (expWb)
				mRegs[rdIdx] = res;
			if (expStore)
				mMem[memIndex(addr)] = rtVal;
			mPc = nextPc;
			mHalted = expHalt;
		end
	endtask

	always
	begin
		@(negedge clk);
		#SAMPLE_DELAY;
		if (!rstN)
			resetModel();
		else
			stepModel();
	end

endmodule

// File: tbTop.sv
`timescale 1ns/1ps

module tbTop;
	import legv8Pkg::*;

	localparam int DMEM_WORDS = 32;
	localparam logic [ADDR_W-1:0] RESET_PC = '0;
	localparam int PROG_DEPTH = 64;
	localparam int PROG_IDX_W = $clog2(PROG_DEPTH);
	localparam logic [ADDR_W-1:0] FETCH_LIMIT = ADDR_W'(PROG_DEPTH * 4);
	localparam int PROG_LEN = 40;
	localparam int NUM_TESTS = 5;
	localparam int MID_RESET_TEST = 4;
	localparam int MID_RESET_CYCLES = 8;
	localparam int HALT_HOLD_CYCLES = 3;
	localparam int RESET_CYCLES = 5;
	localparam int CLK_PERIOD = 20;
	localparam int SEED = 10994;
	localparam int WATCHDOG_NS = NUM_TESTS * (PROG_LEN + 1 + RESET_CYCLES + 20) * CLK_PERIOD;
	localparam logic [INSTR_W-1:0] HALT_WORD = {OPC_HALT, 21'b0};

	logic clk;
	logic rstN;
	logic resetReq;
	logic [INSTR_W-1:0] instr;
	logic [ADDR_W-1:0] instrAddr;
	logic wbValid;
	logic [REG_ADDR_W-1:0] wbReg;
	logic [DATA_W-1:0] wbData;
	logic storeValid;
	logic [DATA_W-1:0] storeAddr;
	logic [DATA_W-1:0] storeData;
	logic halted;
	logic invalidOp;
	int errCount;
	int invalidSeen;
	int testsFailed;
	logic [INSTR_W-1:0] progMem [PROG_DEPTH];

	tbClock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clockGen (
		.resetReq(resetReq), .clk(clk), .rstN(rstN)
	);

	legv8Core #(.DMEM_WORDS(DMEM_WORDS), .RESET_PC(RESET_PC)) i_legv8Core (
		.clk(clk), .rstN(rstN), .instr(instr), .instrAddr(instrAddr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.halted(halted), .invalidOp(invalidOp)
	);

	tbChecker #(.DMEM_WORDS(DMEM_WORDS), .RESET_PC(RESET_PC), .PROG_DEPTH(PROG_DEPTH)) isaCheck (
		.clk(clk), .rstN(rstN), .instrAddr(instrAddr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.halted(halted), .invalidOp(invalidOp),
		.errCount(errCount), .invalidSeen(invalidSeen)
	);

	// HALT past the end of the program
	always_comb
	begin
		if (instrAddr >= FETCH_LIMIT)
			instr = HALT_WORD;
		else
			instr = progMem[instrAddr[2 +: PROG_IDX_W]];
	end

	function automatic logic [INSTR_W-1:0] randomInstr();
		int kind;
		logic [REG_ADDR_W-1:0] ra;
		logic [REG_ADDR_W-1:0] rb;
		logic [REG_ADDR_W-1:0] rc;
		logic [31:0] rnd;
		int off;
		kind = int'($urandom_range(10, 0));
		ra = REG_ADDR_W'($urandom_range(31, 0));
		rb = REG_ADDR_W'($urandom_range(31, 0));
		rc = REG_ADDR_W'($urandom_range(31, 0));
		rnd = $urandom;
		off = int'($urandom_range(4, 1)); // Forward only
		case (kind)
			0: return {OPC_NOP, 21'b0};
			1: return {OPC_LDUR, rnd[8:0], 2'b00, rb, ra};
			2: return {OPC_STUR, rnd[8:0], 2'b00, rb, ra};
			3: return {OPC_ADD, rc, 6'b0, rb, ra};
			4: return {OPC_SUB, rc, 6'b0, rb, ra};
			5: return {OPC_AND, rc, 6'b0, rb, ra};
			6: return {OPC_ORR, rc, 6'b0, rb, ra};
			7: return {OPC_ADDI, rnd[11:0], rb, ra};
			8: return {OPC_CBZ, 19'(off), ra};
			9: return {OPC_CBNZ, 19'(off), ra};
			default: return {OPC_B, 26'(off)};
		endcase
	endfunction

	function automatic logic [INSTR_W-1:0] frozenPcWord(input int n);
		case (n % 3)
			0: return {OPC_ADDI, 12'd1, 5'd0, 5'd1}; // X1 = X0 + 1
			1: return {OPC_STUR, 9'd0, 2'b00, 5'd0, 5'd1};
			default: return {11'b0, 21'b0};
		endcase
	endfunction

	task automatic loadProgram(input logic withInvalid);
		for (int i = 0; i < PROG_DEPTH; i++)
			progMem[i] = HALT_WORD;
		for (int i = 0; i < PROG_LEN; i++)
			progMem[i] = randomInstr();
		if (withInvalid)
		begin
			progMem[0] = {11'b0, 21'($urandom)}; // Always fetched
			progMem[20] = {11'b0, 21'($urandom)};
		end
	endtask

	task automatic pulseReset;
		@(negedge clk);
		resetReq <= 1'b1;
		@(negedge clk);
		resetReq <= 1'b0;
		@(posedge rstN);
	endtask

	task automatic runTest(input int num);
		int errStart;
		int invStart;
		string label;
		errStart = errCount;
		invStart = invalidSeen;
		label = (num == NUM_TESTS) ? "invalid opcode" :
			(num == MID_RESET_TEST) ? "reset mid-program" : "random program";
		loadProgram(num == NUM_TESTS);
		pulseReset();
		if (num == MID_RESET_TEST)
		begin
			repeat (MID_RESET_CYCLES) @(negedge clk);
			pulseReset();
		end
		while (!halted)
			@(negedge clk);
		for (int i = 0; i < HALT_HOLD_CYCLES; i++)
		begin
			// Non-HALT words at the frozen PC must not retire
			progMem[instrAddr[2 +: PROG_IDX_W]] = frozenPcWord(i);
			@(negedge clk);
		end
		if (num == NUM_TESTS && invalidSeen == invStart)
		begin
			$display("Test %0d %s: failed, no invalidOp pulse was seen", num, label);
			testsFailed++;
		end
		else if (errCount != errStart)
		begin
			$display("Test %0d %s: failed with %0d mismatches", num, label, errCount - errStart);
			testsFailed++;
		end
		else
			$display("Test %0d %s: passed", num, label);
	endtask

	initial
	begin
		resetReq = 1'b0;
		testsFailed = 0;
		void'($urandom(SEED));
		for (int t = 1; t <= NUM_TESTS; t++)
			runTest(t);
		$display("Tests run %0d, failed %0d, mismatches %0d", NUM_TESTS, testsFailed, errCount);
		if (testsFailed == 0 && errCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: legv8Core.f
legv8Pkg.sv
ctrlIf.sv
cpuControl.sv
aluUnit.sv
regFile.sv
dataMemory.sv
legv8Core.sv
tbClock.sv
tbChecker.sv
tbTop.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tbTop -f legv8Core.f -o tbSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tbSim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"
if grep -qx "Testbench passed" "$LOG"; then
	exit 0
fi
exit 1
